// ==== common/mem_stage_defs.svh ====
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// Data and address width of the core
`define WORD_WIDTH 32

// Address-space identifier carried with an SFENCE.VMA
`define ASID_WIDTH 9

// Register file index width
`define REG_ADDR_WIDTH 5

`endif

// ==== common/rv32_types_pkg.sv ====
`default_nettype none

`include "mem_stage_defs.svh"

package rv32_types_pkg;

    // One machine word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Memory access width, encoded after the load funct3 field
    // Stores only ever use ACC_B, ACC_H and ACC_W
    typedef enum logic [2:0] {
        ACC_B    = 3'b000,
        ACC_H    = 3'b001,
        ACC_W    = 3'b010,
        ACC_BU   = 3'b100,
        ACC_HU   = 3'b101,
        ACC_NONE = 3'b111
    } access_t;

    // Source of the register write-back value
    typedef enum logic [2:0] {
        WB_DLOAD = 3'd0,
        WB_PC4   = 3'd1,
        WB_IMM_U = 3'd2,
        WB_ALU   = 3'd3,
        WB_CSR   = 3'd4
    } w_sel_t;

endpackage

`default_nettype wire

// ==== common/mem_bus_pkg.sv ====
`default_nettype none

`include "mem_stage_defs.svh"

package mem_bus_pkg;

    // One enable per byte lane, lane n is address byte n
    typedef logic [`WORD_WIDTH/8-1:0] byte_en_t;

    // Exception flags raised by the memory stage
    typedef struct packed {
        logic mal_load;
        logic mal_store;
        logic fault_load;
        logic fault_store;
    } mem_fault_t;

endpackage

`default_nettype wire

// ==== mem_stage/data_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_access (
    input  wire logic                    dren,
    input  wire logic                    dwen,
    input  wire logic                    suppress,
    input  wire rv32_types_pkg::access_t access,
    input  wire rv32_types_pkg::word_t   alu_out,
    input  wire rv32_types_pkg::word_t   rs2_data,
    input  wire logic                    bus_error,
    output logic                         bus_ren,
    output logic                         bus_wen,
    output rv32_types_pkg::word_t        bus_addr,
    output mem_bus_pkg::byte_en_t        bus_byte_en,
    output rv32_types_pkg::word_t        bus_wdata,
    output mem_bus_pkg::mem_fault_t      faults
);

    logic [1:0] offset;
    logic       mal_addr;

    assign bus_addr = alu_out;
    assign offset   = alu_out[1:0];

    // A squashed instruction must not reach the bus
    assign bus_ren = dren & ~suppress;
    assign bus_wen = dwen & ~suppress;

    // Lane enables from the byte offset
    always_comb begin
        case (access)
            rv32_types_pkg::ACC_B, rv32_types_pkg::ACC_BU: begin
                case (offset)
                    2'b00:   bus_byte_en = 4'b0001;
                    2'b01:   bus_byte_en = 4'b0010;
                    2'b10:   bus_byte_en = 4'b0100;
                    default: bus_byte_en = 4'b1000;
                endcase
            end
            rv32_types_pkg::ACC_H, rv32_types_pkg::ACC_HU: begin
                case (offset)
                    2'b00:   bus_byte_en = 4'b0011;
                    2'b10:   bus_byte_en = 4'b1100;
                    default: bus_byte_en = 4'b0000;
                endcase
            end
            rv32_types_pkg::ACC_W: begin
                if (offset == 2'b00) begin
                    bus_byte_en = 4'b1111;
                end else begin
                    bus_byte_en = 4'b0000;
                end
            end
            default: bus_byte_en = 4'b0000;
        endcase
    end

    // Replicate narrow store data so every lane carries it
    always_comb begin
        case (access)
            rv32_types_pkg::ACC_B, rv32_types_pkg::ACC_BU:
                bus_wdata = {4{rs2_data[7:0]}};
            rv32_types_pkg::ACC_H, rv32_types_pkg::ACC_HU:
                bus_wdata = {2{rs2_data[15:0]}};
            rv32_types_pkg::ACC_W:
                bus_wdata = rs2_data;
            default:
                bus_wdata = '0;
        endcase
    end

    // Alignment check
    always_comb begin
        case (access)
            rv32_types_pkg::ACC_W:
                mal_addr = (offset != 2'b00);
            rv32_types_pkg::ACC_H, rv32_types_pkg::ACC_HU:
                mal_addr = offset[0];
            default:
                mal_addr = 1'b0;
        endcase
    end

    assign faults.mal_load    = dren & mal_addr;
    assign faults.mal_store   = dwen & mal_addr;
    assign faults.fault_load  = dren & bus_error;
    assign faults.fault_store = dwen & bus_error;

endmodule

`default_nettype wire

// ==== mem_stage/load_extender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module load_extender (
    input  wire rv32_types_pkg::word_t    bus_rdata,
    input  wire rv32_types_pkg::access_t  access,
    input  wire mem_bus_pkg::byte_en_t    byte_en,
    output rv32_types_pkg::word_t         load_data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Lowest enabled lane
    always_comb begin
        casez (byte_en)
            4'b???1: lane_byte = bus_rdata[7:0];
            4'b??10: lane_byte = bus_rdata[15:8];
            4'b?100: lane_byte = bus_rdata[23:16];
            default: lane_byte = bus_rdata[31:24];
        endcase
    end

    // Lower pair unless only the upper one is enabled
    assign lane_half = byte_en[0] ? bus_rdata[15:0] : bus_rdata[31:16];

    always_comb begin
        case (access)
            rv32_types_pkg::ACC_B:
                load_data = {{(`WORD_WIDTH-8){lane_byte[7]}}, lane_byte};
            rv32_types_pkg::ACC_BU:
                load_data = {{(`WORD_WIDTH-8){1'b0}}, lane_byte};
            rv32_types_pkg::ACC_H:
                load_data = {{(`WORD_WIDTH-16){lane_half[15]}}, lane_half};
            rv32_types_pkg::ACC_HU:
                load_data = {{(`WORD_WIDTH-16){1'b0}}, lane_half};
            rv32_types_pkg::ACC_W:
                load_data = bus_rdata;
            default:
                load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_stage/fence_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fence_tracker (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire logic fence_req,
    input  wire logic done_a,
    input  wire logic done_b,
    output logic      fence_pulse,
    output logic      fence_stall
);

    logic pending;
    logic pending_next;
    logic seen_a;
    logic seen_a_next;
    logic seen_b;
    logic seen_b_next;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending <= 1'b0;
            seen_a  <= 1'b1;
            seen_b  <= 1'b1;
        end else begin
            pending <= pending_next;
            seen_a  <= seen_a_next;
            seen_b  <= seen_b_next;
        end
    end

    // Only a new request fires, a held one waits behind pending
    assign fence_pulse = fence_req & ~pending;

    always_comb begin
        pending_next = pending;
        seen_a_next  = seen_a;
        seen_b_next  = seen_b;
        if (fence_pulse) begin
            pending_next = 1'b1;
            seen_a_next  = 1'b0;
            seen_b_next  = 1'b0;
        end
        // Done strobes may land in the pulse cycle itself
        if (done_a) begin
            seen_a_next = 1'b1;
        end
        if (done_b) begin
            seen_b_next = 1'b1;
        end
        if (seen_a_next && seen_b_next) begin
            pending_next = 1'b0;
        end
    end

    // Pending only survives while a side is still outstanding
    assign fence_stall = pending;

endmodule

`default_nettype wire

// ==== mem_stage/writeback_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_select (
    input  wire rv32_types_pkg::w_sel_t  w_sel,
    input  wire rv32_types_pkg::word_t   load_data,
    input  wire rv32_types_pkg::word_t   pc4,
    input  wire rv32_types_pkg::word_t   imm_u,
    input  wire rv32_types_pkg::word_t   alu_out,
    input  wire rv32_types_pkg::word_t   csr_rdata,
    input  wire logic                    reg_write,
    input  wire logic                    suppress,
    output rv32_types_pkg::word_t        reg_wdata,
    output rv32_types_pkg::word_t        fwd_data,
    output logic                         reg_write_out
);

    always_comb begin
        case (w_sel)
            rv32_types_pkg::WB_DLOAD: reg_wdata = load_data;
            rv32_types_pkg::WB_PC4:   reg_wdata = pc4;
            rv32_types_pkg::WB_IMM_U: reg_wdata = imm_u;
            rv32_types_pkg::WB_ALU:   reg_wdata = alu_out;
            rv32_types_pkg::WB_CSR:   reg_wdata = csr_rdata;
            default:                  reg_wdata = '0;
        endcase
    end

    // Load results arrive too late to forward from here
    assign fwd_data = (w_sel == rv32_types_pkg::WB_DLOAD) ? '0 : reg_wdata;

    // No write-back for a squashed instruction
    assign reg_write_out = reg_write & ~suppress;

endmodule

`default_nettype wire

// ==== mem_stage/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_stage (
    input  wire logic                        CLK,
    input  wire logic                        nRST,
    // Execute/memory pipeline register
    input  wire logic                        dren,
    input  wire logic                        dwen,
    input  wire rv32_types_pkg::access_t     access,
    input  wire rv32_types_pkg::word_t       alu_out,
    input  wire rv32_types_pkg::word_t       rs1_data,
    input  wire rv32_types_pkg::word_t       rs2_data,
    input  wire rv32_types_pkg::word_t       pc4,
    input  wire rv32_types_pkg::word_t       imm_u,
    input  wire rv32_types_pkg::word_t       csr_rdata,
    input  wire rv32_types_pkg::w_sel_t      w_sel,
    input  wire logic                        reg_write,
    input  wire logic [`REG_ADDR_WIDTH-1:0]  rd,
    input  wire logic                        ifence,
    input  wire logic                        sfence,
    input  wire logic                        suppress,
    // Data bus
    input  wire rv32_types_pkg::word_t       bus_rdata,
    input  wire logic                        bus_busy,
    input  wire logic                        bus_error,
    output logic                             bus_ren,
    output logic                             bus_wen,
    output rv32_types_pkg::word_t            bus_addr,
    output mem_bus_pkg::byte_en_t            bus_byte_en,
    output rv32_types_pkg::word_t            bus_wdata,
    // Hazard unit
    output logic                             mem_busy,
    output mem_bus_pkg::mem_fault_t          faults,
    output logic                             fence_stall,
    // Cache and TLB control
    input  wire logic                        iflush_done,
    input  wire logic                        dflush_done,
    input  wire logic                        itlb_done,
    input  wire logic                        dtlb_done,
    output logic                             icache_flush,
    output logic                             dcache_flush,
    output logic                             itlb_fence,
    output logic                             dtlb_fence,
    output logic [`ASID_WIDTH-1:0]           fence_asid,
    output rv32_types_pkg::word_t            fence_va,
    // Write-back and forwarding
    output logic                             reg_write_out,
    output logic [`REG_ADDR_WIDTH-1:0]       rd_out,
    output rv32_types_pkg::word_t            reg_wdata,
    output rv32_types_pkg::word_t            fwd_data
);

    rv32_types_pkg::word_t load_data;
    logic                  cache_pulse;
    logic                  cache_stall;
    logic                  tlb_pulse;
    logic                  tlb_stall;

    data_access u_data_access (
        .dren        (dren),
        .dwen        (dwen),
        .suppress    (suppress),
        .access      (access),
        .alu_out     (alu_out),
        .rs2_data    (rs2_data),
        .bus_error   (bus_error),
        .bus_ren     (bus_ren),
        .bus_wen     (bus_wen),
        .bus_addr    (bus_addr),
        .bus_byte_en (bus_byte_en),
        .bus_wdata   (bus_wdata),
        .faults      (faults)
    );

    // Extraction uses the same lanes that went out on the bus
    load_extender u_load_extender (
        .bus_rdata (bus_rdata),
        .access    (access),
        .byte_en   (bus_byte_en),
        .load_data (load_data)
    );

    writeback_select u_writeback_select (
        .w_sel         (w_sel),
        .load_data     (load_data),
        .pc4           (pc4),
        .imm_u         (imm_u),
        .alu_out       (alu_out),
        .csr_rdata     (csr_rdata),
        .reg_write     (reg_write),
        .suppress      (suppress),
        .reg_wdata     (reg_wdata),
        .fwd_data      (fwd_data),
        .reg_write_out (reg_write_out)
    );

    // FENCE.I flushes both caches
    fence_tracker u_cache_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .fence_req   (ifence),
        .done_a      (iflush_done),
        .done_b      (dflush_done),
        .fence_pulse (cache_pulse),
        .fence_stall (cache_stall)
    );

    // SFENCE.VMA fences both TLBs
    fence_tracker u_tlb_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .fence_req   (sfence),
        .done_a      (itlb_done),
        .done_b      (dtlb_done),
        .fence_pulse (tlb_pulse),
        .fence_stall (tlb_stall)
    );

    assign icache_flush = cache_pulse;
    assign dcache_flush = cache_pulse;
    assign itlb_fence   = tlb_pulse;
    assign dtlb_fence   = tlb_pulse;
    assign fence_stall  = cache_stall | tlb_stall;

    // SFENCE.VMA takes the address from rs1 and the ASID from rs2
    assign fence_asid = rs2_data[`ASID_WIDTH-1:0];
    assign fence_va   = rs1_data;

    assign mem_busy = bus_busy;
    assign rd_out   = rd;

endmodule

`default_nettype wire

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_defs.svh"

module mem_stage_tb;

    localparam rv32_types_pkg::word_t RDATA     = 32'h7f3c_85e1;
    localparam rv32_types_pkg::word_t PC4       = 32'h0000_1004;
    localparam rv32_types_pkg::word_t IMM_U     = 32'h1234_5000;
    localparam rv32_types_pkg::word_t CSR_RDATA = 32'hdead_0b0e;
    localparam rv32_types_pkg::word_t ALU_VAL   = 32'h0000_0a50;
    localparam rv32_types_pkg::word_t STORE_SRC = 32'hcafe_b1a7;
    localparam rv32_types_pkg::word_t FENCE_VA  = 32'hc0de_1000;
    localparam rv32_types_pkg::word_t FENCE_RS2 = 32'h0000_01a5;
    localparam logic [`REG_ADDR_WIDTH-1:0] RD_IDX = 5'd11;

    // One cycle of stimulus and the outputs expected in that cycle
    // done bits are iflush, dflush, itlb, dtlb from high to low
    typedef struct packed {
        logic                    dren;
        logic                    dwen;
        logic                    suppress;
        rv32_types_pkg::access_t access;
        rv32_types_pkg::word_t   alu_out;
        rv32_types_pkg::word_t   rs1_data;
        rv32_types_pkg::word_t   rs2_data;
        rv32_types_pkg::w_sel_t  w_sel;
        logic                    reg_write;
        logic                    ifence;
        logic                    sfence;
        logic [3:0]              done;
        rv32_types_pkg::word_t   bus_rdata;
        logic                    bus_error;
        logic                    exp_ren;
        logic                    exp_wen;
        mem_bus_pkg::byte_en_t   exp_byte_en;
        rv32_types_pkg::word_t   exp_wdata;
        rv32_types_pkg::word_t   exp_reg_wdata;
        rv32_types_pkg::word_t   exp_fwd;
        logic                    exp_reg_write;
        mem_bus_pkg::mem_fault_t exp_faults;
        logic                    exp_cache_flush;
        logic                    exp_tlb_fence;
        logic                    exp_stall;
    } row_t;

    logic CLK;
    logic nRST;
    logic dren;
    logic dwen;
    rv32_types_pkg::access_t access;
    rv32_types_pkg::word_t alu_out;
    rv32_types_pkg::word_t rs1_data;
    rv32_types_pkg::word_t rs2_data;
    rv32_types_pkg::word_t pc4;
    rv32_types_pkg::word_t imm_u;
    rv32_types_pkg::word_t csr_rdata;
    rv32_types_pkg::w_sel_t w_sel;
    logic reg_write;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic ifence;
    logic sfence;
    logic suppress;
    rv32_types_pkg::word_t bus_rdata;
    logic bus_busy;
    logic bus_error;
    logic bus_ren;
    logic bus_wen;
    rv32_types_pkg::word_t bus_addr;
    mem_bus_pkg::byte_en_t bus_byte_en;
    rv32_types_pkg::word_t bus_wdata;
    logic mem_busy;
    mem_bus_pkg::mem_fault_t faults;
    logic fence_stall;
    logic iflush_done;
    logic dflush_done;
    logic itlb_done;
    logic dtlb_done;
    logic icache_flush;
    logic dcache_flush;
    logic itlb_fence;
    logic dtlb_fence;
    logic [`ASID_WIDTH-1:0] fence_asid;
    rv32_types_pkg::word_t fence_va;
    logic reg_write_out;
    logic [`REG_ADDR_WIDTH-1:0] rd_out;
    rv32_types_pkg::word_t reg_wdata;
    rv32_types_pkg::word_t fwd_data;

    row_t rows[$];
    int   errors;
    int   row_idx;
    logic table_ready;
    longint timeout_ns;

    mem_stage u_mem_stage (
        .CLK(CLK), .nRST(nRST),
        .dren(dren), .dwen(dwen), .access(access), .alu_out(alu_out),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc4(pc4), .imm_u(imm_u),
        .csr_rdata(csr_rdata), .w_sel(w_sel), .reg_write(reg_write), .rd(rd),
        .ifence(ifence), .sfence(sfence), .suppress(suppress),
        .bus_rdata(bus_rdata), .bus_busy(bus_busy), .bus_error(bus_error),
        .bus_ren(bus_ren), .bus_wen(bus_wen), .bus_addr(bus_addr),
        .bus_byte_en(bus_byte_en), .bus_wdata(bus_wdata),
        .mem_busy(mem_busy), .faults(faults), .fence_stall(fence_stall),
        .iflush_done(iflush_done), .dflush_done(dflush_done),
        .itlb_done(itlb_done), .dtlb_done(dtlb_done),
        .icache_flush(icache_flush), .dcache_flush(dcache_flush),
        .itlb_fence(itlb_fence), .dtlb_fence(dtlb_fence),
        .fence_asid(fence_asid), .fence_va(fence_va),
        .reg_write_out(reg_write_out), .rd_out(rd_out),
        .reg_wdata(reg_wdata), .fwd_data(fwd_data)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic rv32_types_pkg::word_t lcg(input rv32_types_pkg::word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(input string name, input rv32_types_pkg::word_t got,
                              input rv32_types_pkg::word_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %0t: row %0d %s is %h, expected %h", $time, row_idx, name, got, exp);
        end
    endtask

    task automatic check_byte_en(input string name, input mem_bus_pkg::byte_en_t got,
                                 input mem_bus_pkg::byte_en_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %0t: row %0d %s is %b, expected %b", $time, row_idx, name, got, exp);
        end
    endtask

    task automatic check_faults(input string name, input mem_bus_pkg::mem_fault_t got,
                                input mem_bus_pkg::mem_fault_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %0t: row %0d %s is %b, expected %b", $time, row_idx, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %0t: row %0d %s is %b, expected %b", $time, row_idx, name, got, exp);
        end
    endtask

    // Idle cycle with every output expected low
    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.access = rv32_types_pkg::ACC_NONE;
        r.w_sel = rv32_types_pkg::WB_ALU;
        r.bus_rdata = RDATA;
        return r;
    endfunction

    task automatic add_load(input rv32_types_pkg::access_t acc, input rv32_types_pkg::word_t addr,
                            input rv32_types_pkg::word_t rdata, input mem_bus_pkg::byte_en_t be,
                            input rv32_types_pkg::word_t data);
        row_t r;
        r = blank_row();
        r.dren = 1'b1;
        r.access = acc;
        r.alu_out = addr;
        r.bus_rdata = rdata;
        r.w_sel = rv32_types_pkg::WB_DLOAD;
        r.reg_write = 1'b1;
        r.exp_ren = 1'b1;
        r.exp_byte_en = be;
        r.exp_reg_wdata = data;
        r.exp_reg_write = 1'b1;
        rows.push_back(r);
    endtask

    // Bus access with the address written back through the ALU path
    task automatic add_access(input logic rd_en, input logic wr_en, input logic sup,
                              input rv32_types_pkg::access_t acc,
                              input rv32_types_pkg::word_t addr, input rv32_types_pkg::word_t src,
                              input logic err, input mem_bus_pkg::byte_en_t be,
                              input rv32_types_pkg::word_t wdata,
                              input mem_bus_pkg::mem_fault_t flt);
        row_t r;
        r = blank_row();
        r.dren = rd_en;
        r.dwen = wr_en;
        r.suppress = sup;
        r.access = acc;
        r.alu_out = addr;
        r.rs2_data = src;
        r.bus_error = err;
        r.reg_write = 1'b1;
        r.exp_ren = rd_en & ~sup;
        r.exp_wen = wr_en & ~sup;
        r.exp_byte_en = be;
        r.exp_wdata = wdata;
        r.exp_reg_wdata = addr;
        r.exp_fwd = addr;
        r.exp_reg_write = ~sup;
        r.exp_faults = flt;
        rows.push_back(r);
    endtask

    task automatic add_wb(input rv32_types_pkg::w_sel_t sel, input rv32_types_pkg::word_t data);
        row_t r;
        r = blank_row();
        r.w_sel = sel;
        r.alu_out = ALU_VAL;
        r.reg_write = 1'b1;
        r.exp_reg_wdata = data;
        r.exp_fwd = data;
        r.exp_reg_write = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_fence(input logic i_req, input logic s_req, input logic [3:0] dones,
                             input logic cflush, input logic tfence, input logic stall);
        row_t r;
        r = blank_row();
        r.rs1_data = FENCE_VA;
        r.rs2_data = FENCE_RS2;
        r.ifence = i_req;
        r.sfence = s_req;
        r.done = dones;
        r.exp_cache_flush = cflush;
        r.exp_tlb_fence = tfence;
        r.exp_stall = stall;
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        dren <= r.dren;
        dwen <= r.dwen;
        suppress <= r.suppress;
        access <= r.access;
        alu_out <= r.alu_out;
        rs1_data <= r.rs1_data;
        rs2_data <= r.rs2_data;
        w_sel <= r.w_sel;
        reg_write <= r.reg_write;
        ifence <= r.ifence;
        sfence <= r.sfence;
        iflush_done <= r.done[3];
        dflush_done <= r.done[2];
        itlb_done <= r.done[1];
        dtlb_done <= r.done[0];
        bus_rdata <= r.bus_rdata;
        bus_error <= r.bus_error;
    endtask

    task automatic check_row(input row_t r, input logic busy);
        check_flag("bus_ren", bus_ren, r.exp_ren);
        check_flag("bus_wen", bus_wen, r.exp_wen);
        check_word("bus_addr", bus_addr, r.alu_out);
        check_byte_en("bus_byte_en", bus_byte_en, r.exp_byte_en);
        check_word("bus_wdata", bus_wdata, r.exp_wdata);
        check_word("reg_wdata", reg_wdata, r.exp_reg_wdata);
        check_word("fwd_data", fwd_data, r.exp_fwd);
        check_flag("reg_write_out", reg_write_out, r.exp_reg_write);
        check_faults("faults", faults, r.exp_faults);
        check_flag("icache_flush", icache_flush, r.exp_cache_flush);
        check_flag("dcache_flush", dcache_flush, r.exp_cache_flush);
        check_flag("itlb_fence", itlb_fence, r.exp_tlb_fence);
        check_flag("dtlb_fence", dtlb_fence, r.exp_tlb_fence);
        check_flag("fence_stall", fence_stall, r.exp_stall);
        check_word("fence_va", fence_va, r.rs1_data);
        check_word("fence_asid", {{(`WORD_WIDTH-`ASID_WIDTH){1'b0}}, fence_asid},
                   {{(`WORD_WIDTH-`ASID_WIDTH){1'b0}}, r.rs2_data[`ASID_WIDTH-1:0]});
        check_word("rd_out", {{(`WORD_WIDTH-`REG_ADDR_WIDTH){1'b0}}, rd_out},
                   {{(`WORD_WIDTH-`REG_ADDR_WIDTH){1'b0}}, RD_IDX});
        check_flag("mem_busy", mem_busy, busy);
    endtask

    // Starts counting once the table length is known
    initial begin
        wait (table_ready === 1'b1);
        #(timeout_ns);
        $display("Timeout: the stimulus rows did not finish within %0d ns", timeout_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rv32_types_pkg::word_t seed;
        rv32_types_pkg::word_t addr;
        logic busy;
        table_ready = 1'b0;
        errors = 0;
        row_idx = 0;
        nRST = 1'b0;
        dren = 1'b0;
        dwen = 1'b0;
        suppress = 1'b0;
        access = rv32_types_pkg::ACC_NONE;
        alu_out = '0;
        rs1_data = '0;
        rs2_data = '0;
        pc4 = PC4;
        imm_u = IMM_U;
        csr_rdata = CSR_RDATA;
        w_sel = rv32_types_pkg::WB_ALU;
        reg_write = 1'b0;
        rd = RD_IDX;
        ifence = 1'b0;
        sfence = 1'b0;
        bus_rdata = '0;
        bus_busy = 1'b0;
        bus_error = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        itlb_done = 1'b0;
        dtlb_done = 1'b0;

        // Fence outputs right after reset
        add_fence(1'b0, 1'b0, 4'b0000, 1'b0, 1'b0, 1'b0);
        // Loads from 7f3c_85e1 at every legal offset
        add_load(rv32_types_pkg::ACC_B, 32'h100, RDATA, 4'b0001, 32'hffff_ffe1);
        add_load(rv32_types_pkg::ACC_B, 32'h101, RDATA, 4'b0010, 32'hffff_ff85);
        add_load(rv32_types_pkg::ACC_B, 32'h102, RDATA, 4'b0100, 32'h0000_003c);
        add_load(rv32_types_pkg::ACC_B, 32'h103, RDATA, 4'b1000, 32'h0000_007f);
        add_load(rv32_types_pkg::ACC_BU, 32'h100, RDATA, 4'b0001, 32'h0000_00e1);
        add_load(rv32_types_pkg::ACC_BU, 32'h101, RDATA, 4'b0010, 32'h0000_0085);
        add_load(rv32_types_pkg::ACC_BU, 32'h102, RDATA, 4'b0100, 32'h0000_003c);
        add_load(rv32_types_pkg::ACC_BU, 32'h103, RDATA, 4'b1000, 32'h0000_007f);
        add_load(rv32_types_pkg::ACC_H, 32'h100, RDATA, 4'b0011, 32'hffff_85e1);
        add_load(rv32_types_pkg::ACC_H, 32'h102, RDATA, 4'b1100, 32'h0000_7f3c);
        add_load(rv32_types_pkg::ACC_HU, 32'h100, RDATA, 4'b0011, 32'h0000_85e1);
        add_load(rv32_types_pkg::ACC_HU, 32'h102, RDATA, 4'b1100, 32'h0000_7f3c);
        add_load(rv32_types_pkg::ACC_W, 32'h100, RDATA, 4'b1111, RDATA);
        // Stores followed by a suppressed store and a suppressed load
        add_access(0, 1, 0, rv32_types_pkg::ACC_B, 32'h201, STORE_SRC, 0, 4'b0010,
                   32'ha7a7_a7a7, 4'b0000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_B, 32'h203, STORE_SRC, 0, 4'b1000,
                   32'ha7a7_a7a7, 4'b0000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_H, 32'h200, STORE_SRC, 0, 4'b0011,
                   32'hb1a7_b1a7, 4'b0000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_H, 32'h202, STORE_SRC, 0, 4'b1100,
                   32'hb1a7_b1a7, 4'b0000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_W, 32'h200, STORE_SRC, 0, 4'b1111,
                   STORE_SRC, 4'b0000);
        add_access(0, 1, 1, rv32_types_pkg::ACC_W, 32'h200, STORE_SRC, 0, 4'b1111,
                   STORE_SRC, 4'b0000);
        add_access(1, 0, 1, rv32_types_pkg::ACC_W, 32'h204, 32'h0, 0, 4'b1111,
                   32'h0, 4'b0000);
        // Fault bits are mal_load, mal_store, fault_load, fault_store
        add_access(1, 0, 0, rv32_types_pkg::ACC_H, 32'h301, 32'h0, 0, 4'b0000, 32'h0, 4'b1000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_H, 32'h303, 32'h0, 0, 4'b0000, 32'h0, 4'b0100);
        add_access(1, 0, 0, rv32_types_pkg::ACC_W, 32'h302, 32'h0, 0, 4'b0000, 32'h0, 4'b1000);
        add_access(0, 1, 0, rv32_types_pkg::ACC_W, 32'h301, 32'h0, 0, 4'b0000, 32'h0, 4'b0100);
        add_access(1, 0, 0, rv32_types_pkg::ACC_W, 32'h300, 32'h0, 1, 4'b1111, 32'h0, 4'b0010);
        add_access(0, 1, 0, rv32_types_pkg::ACC_W, 32'h300, 32'h0, 1, 4'b1111, 32'h0, 4'b0001);
        add_wb(rv32_types_pkg::WB_PC4, PC4);
        add_wb(rv32_types_pkg::WB_IMM_U, IMM_U);
        add_wb(rv32_types_pkg::WB_ALU, ALU_VAL);
        add_wb(rv32_types_pkg::WB_CSR, CSR_RDATA);
        // Cache fence with the request held and dones in separate cycles
        add_fence(1'b1, 1'b0, 4'b0000, 1'b1, 1'b0, 1'b0);
        add_fence(1'b1, 1'b0, 4'b0000, 1'b0, 1'b0, 1'b1);
        add_fence(1'b1, 1'b0, 4'b1000, 1'b0, 1'b0, 1'b1);
        add_fence(1'b1, 1'b0, 4'b0100, 1'b0, 1'b0, 1'b1);
        add_fence(1'b0, 1'b0, 4'b0000, 1'b0, 1'b0, 1'b0);
        // TLB fence and then one with both dones in the pulse cycle
        add_fence(1'b0, 1'b1, 4'b0000, 1'b0, 1'b1, 1'b0);
        add_fence(1'b0, 1'b1, 4'b0010, 1'b0, 1'b0, 1'b1);
        add_fence(1'b0, 1'b0, 4'b0001, 1'b0, 1'b0, 1'b1);
        add_fence(1'b0, 1'b0, 4'b0000, 1'b0, 1'b0, 1'b0);
        add_fence(1'b0, 1'b1, 4'b0011, 1'b0, 1'b1, 1'b0);
        add_fence(1'b0, 1'b0, 4'b0000, 1'b0, 1'b0, 1'b0);
        // Random aligned word traffic
        seed = 32'h13def818;
        for (int k = 0; k < 8; k++) begin
            seed = lcg(seed);
            addr = {seed[31:2], 2'b00};
            seed = lcg(seed);
            if (seed[16]) begin
                add_load(rv32_types_pkg::ACC_W, addr, seed, 4'b1111, seed);
            end else begin
                add_access(0, 1, 0, rv32_types_pkg::ACC_W, addr, seed, 0, 4'b1111,
                           seed, 4'b0000);
            end
        end
        timeout_ns = rows.size() * 80 + 400;
        table_ready = 1'b1;

        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge CLK);
            row_idx = i;
            busy = (i % 3) == 1;
            drive_row(rows[i]);
            bus_busy <= busy;
            @(negedge CLK);
            check_row(rows[i], busy);
        end

        $display("%0d errors in %0d rows", errors, rows.size());
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
+incdir+common
common/rv32_types_pkg.sv
common/mem_bus_pkg.sv
mem_stage/data_access.sv
mem_stage/load_extender.sv
mem_stage/fence_tracker.sv
mem_stage/writeback_select.sv
mem_stage/mem_stage.sv
bench/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - include_dirs:
      - common
    files:
      - common/rv32_types_pkg.sv
      - common/mem_bus_pkg.sv
      - mem_stage/data_access.sv
      - mem_stage/load_extender.sv
      - mem_stage/fence_tracker.sv
      - mem_stage/writeback_select.sv
      - mem_stage/mem_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/mem_stage_tb.sv
